//--- logic/intra_config.svh
// --------------------
// Block geometry, pixel width and SAD width
// for the luma intra mode picker
// --------------------

`ifndef INTRA_CONFIG_SVH
`define INTRA_CONFIG_SVH

// Block edge length, 4, 8 or 16
`define BLOCK_SIZE 4

// log2(BLOCK_SIZE) + 1, divisor shift for the DC average of 2*BLOCK_SIZE pixels
`define DC_SHIFT ($clog2(`BLOCK_SIZE) + 1)

`define PIX_W 8

// Wide enough for BLOCK_SIZE^2 differences of full scale
`define SCORE_W (`PIX_W + 2 * $clog2(`BLOCK_SIZE))

`endif

//--- logic/intra_pkg.sv
// --------------------
// Shared types: pixel, edge, block,
// prediction mode and picker result
// --------------------

`default_nettype none

`include "intra_config.svh"

package intra_pkg;

    typedef logic [`PIX_W-1:0] pixel_t;

    // Element 0 is the leftmost (top row) or topmost (left column) pixel
    typedef pixel_t [`BLOCK_SIZE-1:0] edge_t;

    // Indexed as block[row][col]
    typedef edge_t [`BLOCK_SIZE-1:0] block_t;

    // Mode codes in VP8 order
    typedef enum logic [1:0] {
        MODE_DC = 2'd0,
        MODE_TM = 2'd1,
        MODE_V  = 2'd2,
        MODE_H  = 2'd3
    } intra_mode_e;

    typedef struct packed {
        intra_mode_e             mode;
        logic [`SCORE_W-1:0]     score;
        block_t                  pred;
    } result_t;

endpackage

`default_nettype wire

//--- logic/dc_pred.sv
// --------------------
// Sequential DC predictor, walks the
// available edges one pixel per cycle
// --------------------

`timescale 1ns/100ps
`default_nettype none

`include "intra_config.svh"

module dc_pred (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              dc_start,
    input  wire logic              top_avail,
    input  wire logic              left_avail,
    input  wire intra_pkg::edge_t  top_edge,
    input  wire intra_pkg::edge_t  left_edge,
    output intra_pkg::pixel_t      dc_value,
    output logic                   dc_done
);

    localparam int CNT_W = $clog2(`BLOCK_SIZE);
    localparam int SUM_W = `PIX_W + `DC_SHIFT + 1;
    localparam logic [CNT_W-1:0] LAST = CNT_W'(`BLOCK_SIZE - 1);

    // One-hot states
    typedef enum logic [5:0] {
        IDLE = 6'h01,
        BOTH = 6'h02,
        TOP  = 6'h04,
        LEFT = 6'h08,
        NONE = 6'h10,
        DONE = 6'h20
    } dc_state_e;

    dc_state_e          state;
    dc_state_e          state_nxt;
    logic [CNT_W-1:0]   count;
    logic [SUM_W-1:0]   sum;
    logic [SUM_W-1:0]   rounded;

    // --------------------
    // State machine
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (dc_start) begin
                    if (top_avail && left_avail) begin
                        state_nxt = BOTH;
                    end else if (top_avail) begin
                        state_nxt = TOP;
                    end else if (left_avail) begin
                        state_nxt = LEFT;
                    end else begin
                        state_nxt = NONE;
                    end
                end
            end
            BOTH, TOP, LEFT: begin
                if (count == LAST) begin
                    state_nxt = DONE;
                end
            end
            NONE: state_nxt = DONE;
            DONE: state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count   <= '0;
            dc_done <= 1'b0;
        end else begin
            dc_done <= (state == DONE);
            if (state == BOTH || state == TOP || state == LEFT) begin
                count <= count + 1'b1;
            end else begin
                count <= '0;
            end
        end
    end

    // --------------------
    // Accumulator and divide
    // --------------------
    assign rounded = sum + SUM_W'(`BLOCK_SIZE);

    always_ff @(posedge clk) begin
        case (state)
            IDLE: sum <= '0;
            BOTH: sum <= sum + SUM_W'(top_edge[count]) + SUM_W'(left_edge[count]);
            // Single edge counts twice so the shift stays the same
            TOP:  sum <= sum + (SUM_W'(top_edge[count]) << 1);
            LEFT: sum <= sum + (SUM_W'(left_edge[count]) << 1);
            NONE: sum <= SUM_W'(1) << (`PIX_W - 1 + `DC_SHIFT);
            DONE: dc_value <= rounded[`DC_SHIFT +: `PIX_W];
            default: sum <= sum;
        endcase
    end

    a_done_single : assert property (@(posedge clk) disable iff (!rst_n)
        dc_done |=> !dc_done);

endmodule

`default_nettype wire

//--- logic/directional_pred.sv
// --------------------
// V, H and TrueMotion predictors,
// purely combinational
// --------------------

`timescale 1ns/100ps
`default_nettype none

`include "intra_config.svh"

module directional_pred (
    input  wire intra_pkg::edge_t   top_edge,
    input  wire intra_pkg::edge_t   left_edge,
    input  wire intra_pkg::pixel_t  top_left,
    output intra_pkg::block_t       v_pred,
    output intra_pkg::block_t       h_pred,
    output intra_pkg::block_t       tm_pred
);

    for (genvar r = 0; r < `BLOCK_SIZE; r++) begin : g_row
        for (genvar c = 0; c < `BLOCK_SIZE; c++) begin : g_col
            // left + top - corner spans -255..510, two extra bits
            logic [`PIX_W+1:0] tm_sum;

            assign v_pred[r][c] = top_edge[c];
            assign h_pred[r][c] = left_edge[r];

            assign tm_sum = {2'b00, left_edge[r]} + {2'b00, top_edge[c]}
                          - {2'b00, top_left};

            // Sign bit set means below zero, next bit means above full scale
            assign tm_pred[r][c] = tm_sum[`PIX_W+1] ? '0 :
                                   tm_sum[`PIX_W]   ? '1 :
                                                      tm_sum[`PIX_W-1:0];
        end
    end

endmodule

`default_nettype wire

//--- logic/sad_score.sv
// --------------------
// Sum of absolute differences between
// a source block and one candidate
// --------------------

`timescale 1ns/100ps
`default_nettype none

`include "intra_config.svh"

module sad_score (
    input  wire intra_pkg::block_t   src,
    input  wire intra_pkg::block_t   cand,
    output logic [`SCORE_W-1:0]      score
);

    localparam int N = `BLOCK_SIZE * `BLOCK_SIZE;
    localparam int PAD = `SCORE_W - `PIX_W;

    // Heap-ordered tree, leaves at N-1 .. 2N-2, root at 0
    logic [`SCORE_W-1:0] node [2*N-1];

    for (genvar r = 0; r < `BLOCK_SIZE; r++) begin : g_row
        for (genvar c = 0; c < `BLOCK_SIZE; c++) begin : g_col
            intra_pkg::pixel_t diff;

            assign diff = (src[r][c] > cand[r][c]) ? src[r][c] - cand[r][c]
                                                   : cand[r][c] - src[r][c];
            assign node[N - 1 + r * `BLOCK_SIZE + c] = {{PAD{1'b0}}, diff};
        end
    end

    // BLOCK_SIZE is a power of two, so the tree is full
    for (genvar i = 0; i < N - 1; i++) begin : g_tree
        assign node[i] = node[2*i + 1] + node[2*i + 2];
    end

    assign score = node[0];

endmodule

`default_nettype wire

//--- logic/pick_best_intra.sv
// --------------------
// Luma intra mode picker top level
// Control FSM, four SAD scorers,
// min-cost select and result registers
// --------------------

`timescale 1ns/100ps
`default_nettype none

`include "intra_config.svh"

module pick_best_intra (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               start,
    input  wire logic [9:0]         x,
    input  wire logic [9:0]         y,
    input  wire intra_pkg::block_t  src,
    input  wire intra_pkg::edge_t   top_edge,
    input  wire intra_pkg::edge_t   left_edge,
    input  wire intra_pkg::pixel_t  top_left,
    output logic                    busy,
    output logic                    done,
    output intra_pkg::result_t      result
);

    typedef enum logic {
        S_IDLE,
        S_RUN
    } ctrl_state_e;

    ctrl_state_e            state;
    logic                   accept;
    logic                   dc_start;
    logic                   dc_done;
    logic                   top_avail;
    logic                   left_avail;
    logic [3:0]             avail;
    intra_pkg::pixel_t      dc_value;
    intra_pkg::block_t      src_q;
    intra_pkg::edge_t       top_q;
    intra_pkg::edge_t       left_q;
    intra_pkg::pixel_t      top_left_q;
    intra_pkg::block_t      cand [4];
    logic [`SCORE_W-1:0]    cost [4];
    intra_pkg::result_t     best;

    assign busy   = (state == S_RUN);
    assign accept = start && !busy;

    // --------------------
    // Control
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= S_IDLE;
            dc_start   <= 1'b0;
            done       <= 1'b0;
            top_avail  <= 1'b0;
            left_avail <= 1'b0;
            result     <= '0;
        end else begin
            dc_start <= accept;
            done     <= 1'b0;
            if (accept) begin
                state      <= S_RUN;
                top_avail  <= (y != '0);
                left_avail <= (x != '0);
            end else if (busy && dc_done) begin
                state  <= S_IDLE;
                done   <= 1'b1;
                result <= best;
            end
        end
    end

    // Block data and edges
    always_ff @(posedge clk) begin
        if (accept) begin
            src_q      <= src;
            top_q      <= top_edge;
            left_q     <= left_edge;
            top_left_q <= top_left;
        end
    end

    // --------------------
    // Predictors and scorers
    // --------------------
    dc_pred i_dc_pred (
        .clk        (clk),
        .rst_n      (rst_n),
        .dc_start   (dc_start),
        .top_avail  (top_avail),
        .left_avail (left_avail),
        .top_edge   (top_q),
        .left_edge  (left_q),
        .dc_value   (dc_value),
        .dc_done    (dc_done)
    );

    // Candidates sit at their mode code
    assign cand[0] = {(`BLOCK_SIZE * `BLOCK_SIZE){dc_value}};

    directional_pred i_dir_pred (
        .top_edge  (top_q),
        .left_edge (left_q),
        .top_left  (top_left_q),
        .v_pred    (cand[2]),
        .h_pred    (cand[3]),
        .tm_pred   (cand[1])
    );

    for (genvar m = 0; m < 4; m++) begin : g_sad
        sad_score i_sad (
            .src   (src_q),
            .cand  (cand[m]),
            .score (cost[m])
        );
    end

    // DC always available and TM needs both edges
    assign avail = {left_avail, top_avail, top_avail && left_avail, 1'b1};

    // Strict compare in mode order keeps the lower code on a tie
    always_comb begin
        best.mode  = intra_pkg::MODE_DC;
        best.score = cost[0];
        best.pred  = cand[0];
        for (int m = 1; m < 4; m++) begin
            if (avail[m] && cost[m] < best.score) begin
                best.mode  = intra_pkg::intra_mode_e'(m[1:0]);
                best.score = cost[m];
                best.pred  = cand[m];
            end
        end
    end

    a_mode_avail : assert property (@(posedge clk) disable iff (!rst_n)
        done |-> avail[result.mode]);

    // Captured block, edges and availability hold through a run
    a_no_restart : assert property (@(posedge clk) disable iff (!rst_n)
        start && busy |=> $stable(src_q) && $stable(top_q) && $stable(left_q)
                          && $stable(top_left_q) && $stable({top_avail, left_avail}));

endmodule

`default_nettype wire

//--- sim/tb_pick_best_intra.sv
// --------------------
// Testbench for the luma intra mode picker
// Stimulus table, reference model, watchdog
// --------------------

`timescale 1ns/100ps
`default_nettype none

`include "intra_config.svh"

module tb_pick_best_intra;

    localparam int BS = `BLOCK_SIZE;
    localparam int NUM_ROWS = 14;
    localparam int WATCHDOG_CYCLES = NUM_ROWS * (BS + 10) + 50;

    // Source patterns
    localparam logic [2:0] PAT_FLAT = 3'd0;
    localparam logic [2:0] PAT_ROWS = 3'd1;
    localparam logic [2:0] PAT_COLS = 3'd2;
    localparam logic [2:0] PAT_GRAD = 3'd3;
    localparam logic [2:0] PAT_RAND = 3'd4;
    // Table entry with no fixed mode
    localparam logic [2:0] ANY = 3'd4;

    typedef struct packed {
        logic [9:0] x;
        logic [9:0] y;
        logic [2:0] pat;
        logic [2:0] want;
    } stim_row_t;

    localparam stim_row_t TABLE [NUM_ROWS] = '{
        '{10'd3, 10'd5, PAT_FLAT, 3'd0}, '{10'd0, 10'd0, PAT_FLAT, 3'd0},
        '{10'd2, 10'd1, PAT_ROWS, 3'd3}, '{10'd0, 10'd4, PAT_ROWS, ANY},
        '{10'd7, 10'd9, PAT_COLS, 3'd2}, '{10'd0, 10'd3, PAT_COLS, 3'd2},
        '{10'd1, 10'd1, PAT_GRAD, 3'd1}, '{10'd0, 10'd2, PAT_GRAD, ANY},
        '{10'd5, 10'd0, PAT_GRAD, ANY},  '{10'd0, 10'd0, PAT_RAND, 3'd0},
        '{10'd4, 10'd4, PAT_RAND, ANY},  '{10'd0, 10'd6, PAT_RAND, ANY},
        '{10'd8, 10'd0, PAT_RAND, ANY},  '{10'd1023, 10'd1023, PAT_RAND, ANY}
    };

    logic                clk;
    logic                rst_n;
    logic                start;
    logic [9:0]          x;
    logic [9:0]          y;
    intra_pkg::block_t   src;
    intra_pkg::edge_t    top_edge;
    intra_pkg::edge_t    left_edge;
    intra_pkg::pixel_t   top_left;
    logic                busy;
    logic                done;
    intra_pkg::result_t  result;

    integer              seed;
    int                  exp_mode;
    int                  exp_score;
    intra_pkg::block_t   exp_pred;
    int                  pass_count;
    int                  fail_count;

    pick_best_intra i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .x         (x),
        .y         (y),
        .src       (src),
        .top_edge  (top_edge),
        .left_edge (left_edge),
        .top_left  (top_left),
        .busy      (busy),
        .done      (done),
        .result    (result)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Something failed");
        $finish;
    end

    // --------------------
    // Reference model
    // --------------------
    function automatic int abs_diff(input int a, input int b);
        return (a > b) ? a - b : b - a;
    endfunction

    function automatic int clip_pixel(input int v);
        if (v < 0) begin
            return 0;
        end
        if (v > 255) begin
            return 255;
        end
        return v;
    endfunction

    task automatic compute_model();
        intra_pkg::block_t preds [4];
        logic [3:0]        ok;
        int                sum;
        int                dc;
        int                sad;
        // Bit index is the mode code
        ok = {x != 0, y != 0, x != 0 && y != 0, 1'b1};
        sum = 0;
        for (int i = 0; i < BS; i++) begin
            if (ok[2]) sum += int'(top_edge[i]);
            if (ok[3]) sum += int'(left_edge[i]);
        end
        if (ok[2] && ok[3]) begin
            dc = (sum + BS) / (2 * BS);
        end else if (ok[2] || ok[3]) begin
            dc = (sum + BS / 2) / BS;
        end else begin
            dc = 128;
        end
        for (int r = 0; r < BS; r++) begin
            for (int c = 0; c < BS; c++) begin
                preds[0][r][c] = intra_pkg::pixel_t'(dc);
                preds[1][r][c] = intra_pkg::pixel_t'(clip_pixel(int'(left_edge[r])
                                 + int'(top_edge[c]) - int'(top_left)));
                preds[2][r][c] = top_edge[c];
                preds[3][r][c] = left_edge[r];
            end
        end
        for (int m = 0; m < 4; m++) begin
            if (ok[m]) begin
                sad = 0;
                for (int r = 0; r < BS; r++) begin
                    for (int c = 0; c < BS; c++) begin
                        sad += abs_diff(int'(src[r][c]), int'(preds[m][r][c]));
                    end
                end
                // Strict compare keeps the lower mode code on a tie
                if (m == 0 || sad < exp_score) begin
                    exp_mode  = m;
                    exp_score = sad;
                    exp_pred  = preds[m];
                end
            end
        end
    endtask

    // --------------------
    // Stimulus
    // --------------------
    task automatic fill_pattern(input logic [2:0] pat);
        for (int i = 0; i < BS; i++) begin
            top_edge[i]  = intra_pkg::pixel_t'($random(seed));
            left_edge[i] = intra_pkg::pixel_t'($random(seed));
        end
        top_left = intra_pkg::pixel_t'($random(seed));
        if (pat == PAT_ROWS) begin
            for (int c = 0; c < BS; c++) top_edge[c] = intra_pkg::pixel_t'(c * 16 + 3);
        end else if (pat == PAT_GRAD) begin
            // Corner and edges chosen so both clip limits are hit
            for (int i = 0; i < BS; i++) begin
                top_edge[i]  = intra_pkg::pixel_t'((i * 77 + 10) % 256);
                left_edge[i] = intra_pkg::pixel_t'((i * 61 + 20) % 256);
            end
            top_left = 8'd150;
        end
        for (int r = 0; r < BS; r++) begin
            for (int c = 0; c < BS; c++) begin
                case (pat)
                    PAT_FLAT: src[r][c] = 8'h5a;
                    PAT_ROWS: src[r][c] = left_edge[r];
                    PAT_COLS: src[r][c] = top_edge[c];
                    PAT_GRAD: src[r][c] = intra_pkg::pixel_t'(clip_pixel(
                        int'(left_edge[r]) + int'(top_edge[c]) - int'(top_left)));
                    default:  src[r][c] = intra_pkg::pixel_t'($random(seed));
                endcase
            end
        end
        if (pat == PAT_FLAT) begin
            top_edge  = {BS{8'h5a}};
            left_edge = {BS{8'h5a}};
            top_left  = 8'h5a;
        end
    endtask

    task automatic value_error(input string name, input int got, input int want);
        $display("error at %0t: %s = %0d, expected %0d", $time, name, got, want);
    endtask

    task automatic run_row(input int idx);
        stim_row_t          row;
        int                 cycles;
        int                 want_cycles;
        int                 errs;
        intra_pkg::result_t held;
        row = TABLE[idx];
        errs = 0;
        want_cycles = (row.x == 0 && row.y == 0) ? 4 : BS + 3;
        @(posedge clk);
        #2;
        x = row.x;
        y = row.y;
        fill_pattern(row.pat);
        compute_model();
        start = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;
        cycles = 0;
        while (!done) begin
            if (busy !== 1'b1) begin
                value_error("busy", int'(busy), 1);
                errs++;
            end
            @(posedge clk);
            #2;
            cycles++;
            // A start while busy carries other data and must be ignored
            start = (cycles == 2);
            if (cycles == 2) begin
                x = '0;
                y = '0;
                fill_pattern(PAT_RAND);
            end
        end
        start = 1'b0;
        if (busy !== 1'b0) begin
            value_error("busy", int'(busy), 0);
            errs++;
        end
        if (cycles != want_cycles) begin
            value_error("done latency", cycles, want_cycles);
            errs++;
        end
        if (int'(result.mode) != exp_mode) begin
            value_error("result.mode", int'(result.mode), exp_mode);
            errs++;
        end
        if (row.want != ANY && int'(result.mode) != int'(row.want)) begin
            value_error("result.mode (table)", int'(result.mode), int'(row.want));
            errs++;
        end
        if (int'(result.score) != exp_score) begin
            value_error("result.score", int'(result.score), exp_score);
            errs++;
        end
        if (result.pred !== exp_pred) begin
            $display("error at %0t: result.pred = %h, expected %h",
                     $time, result.pred, exp_pred);
            errs++;
        end
        if (row.x == 0 && row.y == 0 && result.pred !== {(BS * BS){8'd128}}) begin
            $display("no-edge prediction is not all 128");
            errs++;
        end
        held = result;
        @(posedge clk);
        #2;
        if (done !== 1'b0) begin
            $display("done stayed high for more than one cycle");
            errs++;
        end
        if (result !== held) begin
            $display("result changed in the cycle after done");
            errs++;
        end
        if (errs == 0) pass_count++;
        else fail_count++;
        $display("row %0d x=%0d y=%0d mode=%0d score=%0d: %s", idx, row.x, row.y,
                 result.mode, result.score, (errs == 0) ? "pass" : "FAIL");
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        seed       = 32'he9ced33e;
        pass_count = 0;
        fail_count = 0;
        rst_n      = 1'b0;
        start      = 1'b0;
        x          = '0;
        y          = '0;
        src        = '0;
        top_edge   = '0;
        left_edge  = '0;
        top_left   = '0;
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;
        if (busy !== 1'b0 || done !== 1'b0 || result !== '0) begin
            $display("outputs are not idle and zero after reset");
            fail_count++;
        end else begin
            pass_count++;
        end
        $display("reset: %s", (fail_count == 0) ? "pass" : "FAIL");
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end
        $display("%0d tests, %0d passed, %0d failed", pass_count + fail_count,
                 pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+logic
logic/intra_pkg.sv
logic/dc_pred.sv
logic/directional_pred.sv
logic/sad_score.sv
logic/pick_best_intra.sv
sim/tb_pick_best_intra.sv

//--- Makefile
# Verilator build and run for the luma intra mode picker

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f src.f --top-module tb_pick_best_intra -Mdir obj_dir
	./obj_dir/Vtb_pick_best_intra | tee $(LOG)
	@grep -q "Everything OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
